// File: uart_pkg.sv
/*
 * UART shared definitions.
 * Bit timing, receive FIFO sizing and the state encodings of the
 * receiver and transmitter state machines.
 */
`default_nettype none

package uart_pkg;

   // One bit period in clock cycles. Kept short so simulation runs fast.
   localparam int CLKS_PER_BIT = 8;
   localparam int HALF_BIT     = CLKS_PER_BIT / 2;
   localparam int CNT_W        = $clog2(CLKS_PER_BIT);

   // Receive FIFO depth, a power of two so the pointers wrap naturally.
   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W = FIFO_PTR_W + 1;

   // The receiver shifts data in behind this marker bit.
   localparam logic [7:0] RX_SENTINEL = 8'h80;
   // Transmit shift register content once all data bits are gone.
   localparam logic [8:0] TX_LAST     = 9'h001;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_t;

endpackage

`default_nettype wire

// File: uart_rx.sv
/*
 * UART receiver.
 * Detects the start bit, samples each data bit at mid-bit, checks the
 * stop bit and holds the received byte valid until it is accepted.
 */
`timescale 1ns/10ps
`default_nettype none

module uart_rx
   import uart_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_rx,
   output logic [7:0] o_data,
   output logic       o_valid,
   input  logic       i_accept,
   output logic       o_frame_err
);

   rx_state_t        state;
   logic [CNT_W-1:0] count;
   logic             rx_s;
   logic             half_end;
   logic             bit_end;

   assign half_end = (count == CNT_W'(HALF_BIT - 1));
   assign bit_end  = (count == CNT_W'(CLKS_PER_BIT - 1));

   // Single sampling flop on the serial input. The line idles high.
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_s <= 1'b1;
      end else begin
         rx_s <= i_rx;
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state       <= RX_IDLE;
         count       <= '0;
         o_data      <= '0;
         o_valid     <= 1'b0;
         o_frame_err <= 1'b0;
      end else begin
         count       <= count + 1'b1;
         o_frame_err <= 1'b0;
         if (i_accept) begin
            o_valid <= 1'b0;
         end
         case (state)
            RX_IDLE: begin
               // A new start bit withdraws any byte still on offer.
               if (!rx_s) begin
                  state   <= RX_START;
                  count   <= '0;
                  o_data  <= RX_SENTINEL;
                  o_valid <= 1'b0;
               end
            end
            RX_START: begin
               if (half_end) begin
                  state <= RX_DATA;
                  count <= '0;
               end
            end
            RX_DATA: begin
               if (bit_end) begin
                  o_data <= {rx_s, o_data[7:1]};
                  count  <= '0;
                  // The sentinel sits in bit 0 when the last data bit arrives.
                  if (o_data[0]) begin
                     state <= RX_STOP;
                  end
               end
            end
            RX_STOP: begin
               // The byte is offered only after its frame has been checked,
               // so a badly framed byte never reaches the FIFO.
               if (bit_end) begin
                  state <= RX_IDLE;
                  count <= '0;
                  if (rx_s) begin
                     o_valid <= 1'b1;
                  end else begin
                     o_frame_err <= 1'b1;
                  end
               end
            end
            default: begin
               state <= RX_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: uart_tx.sv
/*
 * UART transmitter.
 * Latches a byte on a start strobe and sends start bit, eight data
 * bits LSB first and a stop bit, one bit period each.
 */
`timescale 1ns/10ps
`default_nettype none

module uart_tx
   import uart_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic [7:0] i_data,
   input  logic       i_start,
   output logic       o_tx,
   output logic       o_busy
);

   tx_state_t        state;
   logic [CNT_W-1:0] count;
   logic [8:0]       shreg;
   logic             bit_end;

   assign bit_end = (count == CNT_W'(CLKS_PER_BIT - 1));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state  <= TX_IDLE;
         count  <= '0;
         shreg  <= '0;
         o_tx   <= 1'b1;
         o_busy <= 1'b0;
      end else begin
         count <= count + 1'b1;
         case (state)
            TX_IDLE: begin
               // Start strobes are only honoured here, so a strobe while
               // busy is simply dropped.
               if (i_start) begin
                  shreg  <= {1'b1, i_data};
                  state  <= TX_START;
                  count  <= '0;
                  o_tx   <= 1'b0;
                  o_busy <= 1'b1;
               end
            end
            TX_START: begin
               if (bit_end) begin
                  state <= TX_DATA;
                  count <= '0;
                  o_tx  <= shreg[0];
                  shreg <= {1'b0, shreg[8:1]};
               end
            end
            TX_DATA: begin
               if (bit_end) begin
                  count <= '0;
                  // Only the marker bit left means all eight bits are out.
                  if (shreg == TX_LAST) begin
                     state <= TX_STOP;
                     o_tx  <= 1'b1;
                  end else begin
                     o_tx  <= shreg[0];
                     shreg <= {1'b0, shreg[8:1]};
                  end
               end
            end
            TX_STOP: begin
               if (bit_end) begin
                  state  <= TX_IDLE;
                  count  <= '0;
                  o_busy <= 1'b0;
               end
            end
            default: begin
               state <= TX_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: uart_rx_fifo.sv
/*
 * Receive FIFO.
 * Takes one byte per valid from the receiver, presents the oldest
 * byte to the host and pulses overflow when a byte is dropped.
 */
`timescale 1ns/10ps
`default_nettype none

module uart_rx_fifo
   import uart_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic [7:0] i_wdata,
   input  logic       i_wvalid,
   output logic       o_waccept,
   output logic [7:0] o_rdata,
   output logic       o_rvalid,
   input  logic       i_pop,
   output logic       o_overflow
);

   logic [7:0]            mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [FIFO_CNT_W-1:0] count;
   logic                  wvalid_q;
   logic                  full;
   logic                  do_pop;
   logic                  do_write;

   // Accept on the rising edge of valid so a held level writes once.
   assign o_waccept = i_wvalid && !wvalid_q;

   assign full     = (count == FIFO_CNT_W'(FIFO_DEPTH));
   assign o_rvalid = (count != '0);
   assign o_rdata  = mem[rd_ptr];
   assign do_pop   = i_pop && o_rvalid;
   // A pop in the same cycle frees a slot for the incoming byte.
   assign do_write = o_waccept && (!full || do_pop);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         wvalid_q   <= 1'b0;
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         o_overflow <= 1'b0;
      end else begin
         wvalid_q   <= i_wvalid;
         o_overflow <= o_waccept && !do_write;
         if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_write, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (do_write) begin
         mem[wr_ptr] <= i_wdata;
      end
   end

endmodule

`default_nettype wire

// File: uart_core.sv
/*
 * UART core top level.
 * Joins receiver, receive FIFO and transmitter between the serial
 * pins and the host side.
 */
`timescale 1ns/10ps
`default_nettype none

module uart_core (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_rx,
   output logic       o_tx,
   input  logic [7:0] i_tx_data,
   input  logic       i_tx_start,
   output logic       o_tx_busy,
   output logic [7:0] o_rx_data,
   output logic       o_rx_valid,
   input  logic       i_rx_pop,
   output logic       o_rx_overflow,
   output logic       o_frame_err
);

   logic [7:0] rx_byte;
   logic       rx_valid;
   logic       rx_accept;

   uart_rx u_rx (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_rx        (i_rx),
      .o_data      (rx_byte),
      .o_valid     (rx_valid),
      .i_accept    (rx_accept),
      .o_frame_err (o_frame_err)
   );

   // The FIFO is the only place that knows about fullness.
   uart_rx_fifo u_rx_fifo (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_wdata    (rx_byte),
      .i_wvalid   (rx_valid),
      .o_waccept  (rx_accept),
      .o_rdata    (o_rx_data),
      .o_rvalid   (o_rx_valid),
      .i_pop      (i_rx_pop),
      .o_overflow (o_rx_overflow)
   );

   uart_tx u_tx (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_data  (i_tx_data),
      .i_start (i_tx_start),
      .o_tx    (o_tx),
      .o_busy  (o_tx_busy)
   );

endmodule

`default_nettype wire

// File: uart_properties.sv
/*
 * UART core pin properties.
 * Bound into the core to check the idle line level, single-cycle
 * status pulses and that received data stays valid until popped.
 */
`timescale 1ns/10ps
`default_nettype none

module uart_properties (
   input logic i_clk,
   input logic i_nrst,
   input logic i_tx,
   input logic i_tx_busy,
   input logic i_rx_valid,
   input logic i_rx_pop,
   input logic i_rx_overflow,
   input logic i_frame_err
);

   // The serial output idles high whenever no frame is on its way.
   tx_idle_high: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !i_tx_busy |-> i_tx)
      else $error("o_tx is low while the transmitter is idle");

   frame_err_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_frame_err |=> !i_frame_err)
      else $error("o_frame_err is longer than one cycle");

   overflow_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_rx_overflow |=> !i_rx_overflow)
      else $error("o_rx_overflow is longer than one cycle");

   // Only the host removes bytes.
   rx_valid_held: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_rx_valid && !i_rx_pop |=> i_rx_valid)
      else $error("o_rx_valid fell without a pop");

endmodule

bind uart_core uart_properties props0 (
   .i_clk         (i_clk),
   .i_nrst        (i_nrst),
   .i_tx          (o_tx),
   .i_tx_busy     (o_tx_busy),
   .i_rx_valid    (o_rx_valid),
   .i_rx_pop      (i_rx_pop),
   .i_rx_overflow (o_rx_overflow),
   .i_frame_err   (o_frame_err)
);

`default_nettype wire

// File: uart_tb.sv
/*
 * Testbench for the UART core.
 * Reads commands from the stim file, drives serial frames and host
 * strobes, and checks received bytes, errors and transmitted frames.
 */
`timescale 1ns/10ps
`default_nettype none

module uart_tb
   import uart_pkg::*;
();

   logic       i_clk;
   logic       i_nrst;
   logic       i_rx;
   logic [7:0] i_tx_data;
   logic       i_tx_start;
   logic       i_rx_pop;
   logic       o_tx;
   logic       o_tx_busy;
   logic [7:0] o_rx_data;
   logic       o_rx_valid;
   logic       o_rx_overflow;
   logic       o_frame_err;

   // Three bytes per command: op, arg1, arg2.
   logic [7:0] stim_mem [0:255];
   logic [7:0] model_q [$];
   int         accept_cnt = 0;
   int         ferr_cnt = 0;
   int         ovf_cnt = 0;
   int         watchdog_cycles = 0;

   uart_core dut0 (
      .i_clk         (i_clk),
      .i_nrst        (i_nrst),
      .i_rx          (i_rx),
      .o_tx          (o_tx),
      .i_tx_data     (i_tx_data),
      .i_tx_start    (i_tx_start),
      .o_tx_busy     (o_tx_busy),
      .o_rx_data     (o_rx_data),
      .o_rx_valid    (o_rx_valid),
      .i_rx_pop      (i_rx_pop),
      .o_rx_overflow (o_rx_overflow),
      .o_frame_err   (o_frame_err)
   );

   initial begin
      i_clk = 1'b0;
      forever #2 i_clk = ~i_clk;
   end

   // Count receiver hand-overs and status pulses. The main flow reads these at negedges.
   always @(posedge i_clk) begin
      if (i_nrst) begin
         if (dut0.rx_accept) accept_cnt = accept_cnt + 1;
         if (o_frame_err) ferr_cnt = ferr_cnt + 1;
         if (o_rx_overflow) ovf_cnt = ovf_cnt + 1;
      end
   end

   task automatic abort_run();
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped after a failed check");
   endtask

   task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got == exp)
         else begin
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
            abort_run();
         end
   endtask

   task automatic drive_bit(input logic value, input int cycles);
      @(posedge i_clk);
      i_rx <= value;
      repeat (cycles - 1) @(posedge i_clk);
   endtask

   task automatic send_frame(input logic [7:0] data, input logic stop_ok);
      int i;
      drive_bit(1'b0, CLKS_PER_BIT);
      for (i = 0; i < 8; i++) drive_bit(data[i], CLKS_PER_BIT);
      if (stop_ok) begin
         drive_bit(1'b1, CLKS_PER_BIT);
      end else begin
         // The line goes back high right after the mid-bit sample, so the
         // tail of the bad stop bit is not taken for a new start bit.
         drive_bit(1'b0, HALF_BIT + 1);
         drive_bit(1'b1, CLKS_PER_BIT - HALF_BIT - 1);
      end
   endtask

   task automatic check_fifo_head();
      expect_eq("o_rx_valid", o_rx_valid, model_q.size() != 0);
      if (model_q.size() != 0) expect_eq("o_rx_data", o_rx_data, model_q[0]);
   endtask

   task automatic rx_frames(input int count, input logic [7:0] first);
      int         i;
      int         base_acc;
      int         base_ovf;
      int         base_ferr;
      int         exp_ovf;
      int         waited;
      logic [7:0] data;
      base_acc  = accept_cnt;
      base_ovf  = ovf_cnt;
      base_ferr = ferr_cnt;
      exp_ovf   = 0;
      for (i = 0; i < count; i++) begin
         data = first + 8'(i);
         // A full FIFO drops the byte.
         if (model_q.size() < FIFO_DEPTH) model_q.push_back(data);
         else exp_ovf++;
         send_frame(data, 1'b1);
      end
      waited = 0;
      @(negedge i_clk);
      while (accept_cnt < base_acc + count && waited < 2 * CLKS_PER_BIT) begin
         @(negedge i_clk);
         waited++;
      end
      assert (accept_cnt >= base_acc + count)
         else begin
            $display("receiver did not hand all %0d bytes to the FIFO in time", count);
            abort_run();
         end
      // The overflow flag is registered one cycle after the hand-over.
      repeat (2) @(negedge i_clk);
      expect_eq("o_rx_overflow pulses", ovf_cnt - base_ovf, exp_ovf);
      expect_eq("o_frame_err pulses", ferr_cnt - base_ferr, 0);
      check_fifo_head();
   endtask

   task automatic bad_frame(input logic [7:0] data);
      int base_acc;
      int base_ferr;
      int waited;
      base_acc  = accept_cnt;
      base_ferr = ferr_cnt;
      send_frame(data, 1'b0);
      waited = 0;
      @(negedge i_clk);
      while (ferr_cnt == base_ferr && waited < 2 * CLKS_PER_BIT) begin
         @(negedge i_clk);
         waited++;
      end
      assert (ferr_cnt != base_ferr)
         else begin
            $display("no framing error was reported for a frame with a low stop bit");
            abort_run();
         end
      repeat (2) @(negedge i_clk);
      expect_eq("o_frame_err pulses", ferr_cnt - base_ferr, 1);
      expect_eq("rx_accept pulses", accept_cnt - base_acc, 0);
      check_fifo_head();
   endtask

   task automatic pop_byte(input logic [7:0] expected);
      logic [7:0] front;
      @(negedge i_clk);
      check_fifo_head();
      if (model_q.size() != 0) begin
         front = model_q.pop_front();
         assert (front == expected)
            else begin
               $display("stim file expects byte %h but the FIFO model holds %h", expected, front);
               abort_run();
            end
      end
      @(posedge i_clk);
      i_rx_pop <= 1'b1;
      @(posedge i_clk);
      i_rx_pop <= 1'b0;
      @(negedge i_clk);
      check_fifo_head();
   endtask

   task automatic start_tx(input logic [7:0] data);
      @(posedge i_clk);
      i_tx_data  <= data;
      i_tx_start <= 1'b1;
      @(posedge i_clk);
      i_tx_start <= 1'b0;
   endtask

   task automatic check_tx_frame(input logic [7:0] data);
      logic [9:0] frame;
      int         waited;
      int         c;
      frame  = {1'b1, data, 1'b0};
      waited = 0;
      @(negedge i_clk);
      while (o_tx && waited < 2 * CLKS_PER_BIT) begin
         @(negedge i_clk);
         waited++;
      end
      assert (!o_tx)
         else begin
            $display("transmitter sent no start bit after the start strobe");
            abort_run();
         end
      // Cycle c counts from the falling start edge; bits are sampled mid-bit.
      c = 0;
      while (o_tx_busy && c <= 10 * CLKS_PER_BIT) begin
         if (c % CLKS_PER_BIT == HALF_BIT && c / CLKS_PER_BIT < 10) begin
            expect_eq($sformatf("o_tx bit %0d", c / CLKS_PER_BIT), o_tx,
                      frame[c / CLKS_PER_BIT]);
         end
         c++;
         @(negedge i_clk);
      end
      expect_eq("o_tx_busy cycles", c, 10 * CLKS_PER_BIT);
   endtask

   task automatic double_start_tx(input logic [7:0] first, input logic [7:0] second);
      fork
         begin
            start_tx(first);
            check_tx_frame(first);
         end
         begin
            repeat (2 * CLKS_PER_BIT) @(posedge i_clk);
            start_tx(second);
         end
      join
      // The ignored second byte must not start a frame of its own.
      repeat (2 * CLKS_PER_BIT) begin
         @(negedge i_clk);
         expect_eq("o_tx_busy", o_tx_busy, 1'b0);
         expect_eq("o_tx", o_tx, 1'b1);
      end
   endtask

   initial begin
      int         idx;
      int         weight;
      logic [7:0] op;
      i_nrst     = 1'b0;
      i_rx       = 1'b1;
      i_tx_data  = 8'h00;
      i_tx_start = 1'b0;
      i_rx_pop   = 1'b0;
      for (idx = 0; idx < 256; idx++) stim_mem[idx] = 8'h00;
      $readmemh("uart_stim.txt", stim_mem);
      // A burst weighs as many frames as it sends.
      weight = 0;
      idx    = 0;
      while (idx < 85 && stim_mem[3 * idx] != 8'h00) begin
         weight += (stim_mem[3 * idx] == 8'h03) ? int'(stim_mem[3 * idx + 1]) : 1;
         idx++;
      end
      watchdog_cycles = weight * 12 * CLKS_PER_BIT + 100;
      repeat (3) @(posedge i_clk);
      i_nrst <= 1'b1;
      @(negedge i_clk);
      expect_eq("o_tx", o_tx, 1'b1);
      expect_eq("o_tx_busy", o_tx_busy, 1'b0);
      expect_eq("o_rx_valid", o_rx_valid, 1'b0);
      expect_eq("o_rx_overflow", o_rx_overflow, 1'b0);
      expect_eq("o_frame_err", o_frame_err, 1'b0);
      idx = 0;
      while (idx < 85 && stim_mem[3 * idx] != 8'h00) begin
         op = stim_mem[3 * idx];
         case (op)
            8'h01: rx_frames(1, stim_mem[3 * idx + 1]);
            8'h02: bad_frame(stim_mem[3 * idx + 1]);
            8'h03: rx_frames(int'(stim_mem[3 * idx + 1]), stim_mem[3 * idx + 2]);
            8'h04: pop_byte(stim_mem[3 * idx + 1]);
            8'h05: begin
               start_tx(stim_mem[3 * idx + 1]);
               check_tx_frame(stim_mem[3 * idx + 1]);
            end
            8'h06: double_start_tx(stim_mem[3 * idx + 1], stim_mem[3 * idx + 2]);
            default: begin
               $display("unknown command %h in the stim file", op);
               abort_run();
            end
         endcase
         idx++;
      end
      @(negedge i_clk);
      check_fifo_head();
      $display("STATUS: PASS");
      $finish;
   end

   initial begin
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge i_clk);
      $display("timeout after %0d clock cycles before all commands finished", watchdog_cycles);
      abort_run();
   end

endmodule

`default_nettype wire

// File: uart_stim.txt
// Columns: op arg1 arg2, hex. op 01 good rx frame arg1, 02 rx frame arg1 with low stop bit,
// 03 burst of arg1 frames from byte arg2, 04 pop expecting arg1, 05 transmit arg1,
// 06 transmit arg1 and strobe arg2 while busy, 00 ends the list.
01 A5 00
04 A5 00
01 3C 00
01 C3 00
04 3C 00
04 C3 00
02 5A 00
01 81 00
04 81 00
// Six frames into a four-byte FIFO, two of them overflow.
03 06 10
04 10 00
04 11 00
04 12 00
04 13 00
// Pop on an empty FIFO is ignored.
04 00 00
02 FF 00
01 00 00
01 FF 00
04 00 00
04 FF 00
05 55 00
05 00 00
05 FF 00
06 96 69
05 01 00
00 00 00

// File: uart_core.f
uart_pkg.sv
uart_rx.sv
uart_tx.sv
uart_rx_fifo.sv
uart_core.sv
uart_properties.sv
uart_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the UART core testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module uart_tb -f uart_core.f > "$log" 2>&1 \
   && ./obj_dir/Vuart_tb >> "$log" 2>&1 \
   || echo "Verilator build or simulation returned an error" >> "$log"

cat "$log"

grep -qx "STATUS: PASS" "$log" \
   && { echo "Simulation passed."; exit 0; } \
   || { echo "Simulation failed, see $log."; exit 1; }
